/* qpix_daq_defines.svh */
`ifndef QPIX_DAQ_DEFINES_SVH
`define QPIX_DAQ_DEFINES_SVH

//////////////////////////////////////////////////
// sizes shared by the whole readout core
//////////////////////////////////////////////////

// number of lvds hit inputs
`define QPIX_NUM_CHANNELS 16

// free running timestamp width
`define QPIX_TS_WIDTH 64

// shared event buffer entries
// small on purpose so the full state is easy to reach
`define QPIX_BUF_DEPTH 8
`define QPIX_BUF_AW 3

// register port data width
`define QPIX_REG_WIDTH 32

// fixed value returned by the id register
`define QPIX_ID_VALUE 32'hdeadbeef

`endif

/* qpix_daq_pkg.sv */
`include "qpix_daq_defines.svh"

package qpix_daq_pkg;

    // one counter value
    typedef logic [`QPIX_TS_WIDTH-1:0] timestamp_t;

    // hit channel number
    typedef logic [$clog2(`QPIX_NUM_CHANNELS)-1:0] channel_t;

    // one register word
    typedef logic [`QPIX_REG_WIDTH-1:0] reg_data_t;

    // register map
    typedef enum logic [3:0] {
        reg_control      = 4'd0,
        reg_chan_enable  = 4'd1,
        reg_trig_ts_hi   = 4'd2,
        reg_trig_ts_lo   = 4'd3,
        reg_event_hi     = 4'd4,
        reg_event_lo     = 4'd5,
        reg_event_status = 4'd6,
        reg_overrun      = 4'd7,
        reg_pop          = 4'd8,
        reg_id           = 4'd9
    } reg_addr_e;

    // per channel hit holder
    typedef enum logic {
        hit_idle    = 1'b0,
        hit_pending = 1'b1
    } hit_state_e;

endpackage

/* timestamp_counter.sv */
module timestamp_counter (
    input  logic                    clk200,
    input  logic                    counter_reset,
    input  logic                    trigger,
    output qpix_daq_pkg::timestamp_t count,
    output qpix_daq_pkg::timestamp_t trig_ts
);

    // trigger seen one cycle ago
    logic trigger_d;
    logic trigger_rise;

    // free running counter
    // the edge with reset high leaves it at zero
    always_ff @(posedge clk200)
    begin
        if (counter_reset)
            count <= '0;
        else
            count <= count + 1'b1;
    end

    // rising edge of the trigger level
    assign trigger_rise = trigger & ~trigger_d;

    // trigger is written at edge k, seen high until edge k+1
    // so the count sampled here is still ts(k)
    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            trigger_d <= 1'b0;
            trig_ts   <= '0;
        end
        else
        begin
            trigger_d <= trigger;
            if (trigger_rise)
                trig_ts <= count;
        end
    end

endmodule

/* hit_channel.sv */
`include "qpix_daq_defines.svh"

module hit_channel (
    input  logic                     clk200,
    input  logic                     counter_reset,
    input  logic                     lvds_in,
    input  logic                     enable,
    input  qpix_daq_pkg::timestamp_t count,
    input  logic                     grant,
    input  logic                     overrun_clear,
    output logic                     request,
    output qpix_daq_pkg::timestamp_t hit_ts,
    output logic                     overrun
);

    import qpix_daq_pkg::*;

    //////////////////////////////////////////////////
    // input synchronizer and edge detect
    //////////////////////////////////////////////////

    logic       sync_0;
    logic       sync_1;
    logic       sync_d;
    logic       hit_rise;
    hit_state_e state;

    // two flop sync, then one more flop for the edge
    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            sync_0 <= 1'b0;
            sync_1 <= 1'b0;
            sync_d <= 1'b0;
        end
        else
        begin
            sync_0 <= lvds_in;
            sync_1 <= sync_0;
            sync_d <= sync_1;
        end
    end

    // first sampled at edge k, taken at edge k+2
    assign hit_rise = sync_1 & ~sync_d;

    //////////////////////////////////////////////////
    // pending hold
    //////////////////////////////////////////////////

    always_ff @(posedge clk200)
    begin
        if (counter_reset)
            state <= hit_idle;
        else
        begin
            case (state)
                hit_idle:
                    if (hit_rise && enable)
                        state <= hit_pending;
                // leave only once the arbiter has taken the event
                hit_pending:
                    if (grant)
                        state <= hit_idle;
                default:
                    state <= hit_idle;
            endcase
        end
    end

    // stamp is payload, loaded only when a hit is accepted
    always_ff @(posedge clk200)
    begin
        if (state == hit_idle && hit_rise && enable)
            hit_ts <= count;
    end

    // sticky overrun, a new hit beats the clear
    always_ff @(posedge clk200)
    begin
        if (counter_reset)
            overrun <= 1'b0;
        else if (state == hit_pending && hit_rise)
            overrun <= 1'b1;
        else if (overrun_clear)
            overrun <= 1'b0;
    end

    assign request = (state == hit_pending);

endmodule

/* event_arbiter.sv */
`include "qpix_daq_defines.svh"

module event_arbiter (
    input  logic                                clk200,
    input  logic                                counter_reset,
    input  logic [`QPIX_NUM_CHANNELS-1:0]       request,
    input  qpix_daq_pkg::timestamp_t            hit_ts [`QPIX_NUM_CHANNELS],
    input  logic                                buf_full,
    output logic [`QPIX_NUM_CHANNELS-1:0]       grant,
    output logic                                push,
    output qpix_daq_pkg::channel_t              push_channel,
    output qpix_daq_pkg::timestamp_t            push_ts
);

    import qpix_daq_pkg::*;

    // channel that won the last grant
    channel_t last_grant;
    // next requester after last_grant
    channel_t sel;
    logic     found;

    // search starts one past the last winner and wraps
    always_comb
    begin
        channel_t idx;
        found = 1'b0;
        sel   = last_grant;
        for (int i = 1; i <= `QPIX_NUM_CHANNELS; i++)
        begin
            // cast wraps the index around the channel count
            idx = last_grant + channel_t'(i);
            if (!found && request[idx])
            begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    // no grant at all while the buffer is full
    assign grant = (found && !buf_full) ?
                   ({{(`QPIX_NUM_CHANNELS-1){1'b0}}, 1'b1} << sel) : '0;

    assign push         = |grant;
    assign push_channel = sel;
    assign push_ts      = hit_ts[sel];

    // pointer moves only on an actual push
    // reset value makes channel 0 first in line
    always_ff @(posedge clk200)
    begin
        if (counter_reset)
            last_grant <= channel_t'(`QPIX_NUM_CHANNELS - 1);
        else if (push)
            last_grant <= sel;
    end

endmodule

/* event_buffer.sv */
`include "qpix_daq_defines.svh"

module event_buffer (
    input  logic                     clk200,
    input  logic                     counter_reset,
    input  logic                     push,
    input  qpix_daq_pkg::channel_t   push_channel,
    input  qpix_daq_pkg::timestamp_t push_ts,
    input  logic                     pop,
    output qpix_daq_pkg::channel_t   head_channel,
    output qpix_daq_pkg::timestamp_t head_ts,
    output logic                     empty,
    output logic                     full,
    output logic [`QPIX_BUF_AW:0]    count
);

    import qpix_daq_pkg::*;

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    // event word kept as two parallel arrays
    channel_t   mem_channel [`QPIX_BUF_DEPTH];
    timestamp_t mem_ts      [`QPIX_BUF_DEPTH];

    logic [`QPIX_BUF_AW-1:0] wr_ptr;
    logic [`QPIX_BUF_AW-1:0] rd_ptr;
    logic                    do_pop;

    // the arbiter never pushes while full
    // pop on empty is dropped here
    assign do_pop = pop & ~empty;

    always_ff @(posedge clk200)
    begin
        if (push)
        begin
            mem_channel[wr_ptr] <= push_channel;
            mem_ts[wr_ptr]      <= push_ts;
        end
    end

    //////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////

    // depth is a power of two so pointers just wrap
    always_ff @(posedge clk200)
    begin
        if (counter_reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            // simultaneous push and pop keeps the count
            case ({push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign empty = (count == '0);
    assign full  = (count == `QPIX_BUF_DEPTH);

    // head shown without a read strobe
    assign head_channel = mem_channel[rd_ptr];
    assign head_ts      = mem_ts[rd_ptr];

endmodule

/* register_bank.sv */
`include "qpix_daq_defines.svh"

module register_bank (
    input  logic                              clk200,
    input  logic                              counter_reset,
    input  logic                              reg_wr,
    input  qpix_daq_pkg::reg_addr_e           reg_addr,
    input  qpix_daq_pkg::reg_data_t           reg_wdata,
    input  qpix_daq_pkg::timestamp_t          trig_ts,
    input  qpix_daq_pkg::channel_t            head_channel,
    input  qpix_daq_pkg::timestamp_t          head_ts,
    input  logic                              empty,
    input  logic                              full,
    input  logic [`QPIX_BUF_AW:0]             count,
    input  logic [`QPIX_NUM_CHANNELS-1:0]     overrun,
    output qpix_daq_pkg::reg_data_t           reg_rdata,
    output logic                              trigger,
    output logic [`QPIX_NUM_CHANNELS-1:0]     chan_enable,
    output logic                              pop,
    output logic [`QPIX_NUM_CHANNELS-1:0]     overrun_clear
);

    import qpix_daq_pkg::*;

    //////////////////////////////////////////////////
    // write side
    //////////////////////////////////////////////////

    logic wr_control;
    logic wr_enable;
    logic wr_overrun;
    logic wr_pop;

    // address decode of the write strobe
    assign wr_control = reg_wr && (reg_addr == reg_control);
    assign wr_enable  = reg_wr && (reg_addr == reg_chan_enable);
    assign wr_overrun = reg_wr && (reg_addr == reg_overrun);
    assign wr_pop     = reg_wr && (reg_addr == reg_pop);

    // trigger level follows control bit 0
    // high from the edge after the write
    always_ff @(posedge clk200)
    begin
        if (counter_reset)
            trigger <= 1'b0;
        else if (wr_control)
            trigger <= reg_wdata[0];
    end

    // hit enable mask, all channels live out of reset
    always_ff @(posedge clk200)
    begin
        if (counter_reset)
            chan_enable <= '1;
        else if (wr_enable)
            chan_enable <= reg_wdata[`QPIX_NUM_CHANNELS-1:0];
    end

    // strobes act at the same edge as the write
    // data bits pick which overrun flags to clear
    assign pop           = wr_pop;
    assign overrun_clear = wr_overrun ? reg_wdata[`QPIX_NUM_CHANNELS-1:0] : '0;

    //////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////

    // combinational read, unmapped addresses give zero
    always_comb
    begin
        reg_rdata = '0;
        case (reg_addr)
            reg_control:
                reg_rdata[0] = trigger;
            reg_chan_enable:
                reg_rdata[`QPIX_NUM_CHANNELS-1:0] = chan_enable;
            reg_trig_ts_hi:
                reg_rdata = trig_ts[63:32];
            reg_trig_ts_lo:
                reg_rdata = trig_ts[31:0];
            reg_event_hi:
                reg_rdata = head_ts[63:32];
            reg_event_lo:
                reg_rdata = head_ts[31:0];
            reg_event_status:
            begin
                // head channel, flags, then occupancy
                reg_rdata[3:0]   = head_channel;
                reg_rdata[8]     = empty;
                reg_rdata[9]     = full;
                reg_rdata[19:16] = count;
            end
            reg_overrun:
                reg_rdata[`QPIX_NUM_CHANNELS-1:0] = overrun;
            reg_id:
                reg_rdata = `QPIX_ID_VALUE;
            default:
                reg_rdata = '0;
        endcase
    end

endmodule

/* qpix_daq_top.sv */
`include "qpix_daq_defines.svh"

module qpix_daq_top (
    input  logic                          clk200,
    input  logic                          counter_reset,
    input  logic [`QPIX_NUM_CHANNELS-1:0] lvds_hit,
    input  logic                          reg_wr,
    input  qpix_daq_pkg::reg_addr_e       reg_addr,
    input  qpix_daq_pkg::reg_data_t       reg_wdata,
    output qpix_daq_pkg::reg_data_t       reg_rdata,
    output logic                          trigger
);

    import qpix_daq_pkg::*;

    //////////////////////////////////////////////////
    // internal nets
    //////////////////////////////////////////////////

    // counter and trigger stamp
    timestamp_t ts_count;
    timestamp_t trig_ts;

    // per channel hit state
    logic [`QPIX_NUM_CHANNELS-1:0] chan_enable;
    logic [`QPIX_NUM_CHANNELS-1:0] request;
    logic [`QPIX_NUM_CHANNELS-1:0] grant;
    logic [`QPIX_NUM_CHANNELS-1:0] overrun;
    logic [`QPIX_NUM_CHANNELS-1:0] overrun_clear;
    timestamp_t                    hit_ts [`QPIX_NUM_CHANNELS];

    // arbiter to buffer
    logic       push;
    channel_t   push_channel;
    timestamp_t push_ts;

    // buffer head and status
    logic                  pop;
    channel_t              head_channel;
    timestamp_t            head_ts;
    logic                  empty;
    logic                  full;
    logic [`QPIX_BUF_AW:0] buf_count;

    timestamp_counter i_timestamp_counter (
        .clk200        (clk200),
        .counter_reset (counter_reset),
        .trigger       (trigger),
        .count         (ts_count),
        .trig_ts       (trig_ts)
    );

    // one holder per lvds input
    for (genvar i = 0; i < `QPIX_NUM_CHANNELS; i++)
    begin : g_hit
        hit_channel i_hit_channel (
            .clk200        (clk200),
            .counter_reset (counter_reset),
            .lvds_in       (lvds_hit[i]),
            .enable        (chan_enable[i]),
            .count         (ts_count),
            .grant         (grant[i]),
            .overrun_clear (overrun_clear[i]),
            .request       (request[i]),
            .hit_ts        (hit_ts[i]),
            .overrun       (overrun[i])
        );
    end

    event_arbiter i_event_arbiter (
        .clk200        (clk200),
        .counter_reset (counter_reset),
        .request       (request),
        .hit_ts        (hit_ts),
        .buf_full      (full),
        .grant         (grant),
        .push          (push),
        .push_channel  (push_channel),
        .push_ts       (push_ts)
    );

    event_buffer i_event_buffer (
        .clk200        (clk200),
        .counter_reset (counter_reset),
        .push          (push),
        .push_channel  (push_channel),
        .push_ts       (push_ts),
        .pop           (pop),
        .head_channel  (head_channel),
        .head_ts       (head_ts),
        .empty         (empty),
        .full          (full),
        .count         (buf_count)
    );

    register_bank i_register_bank (
        .clk200        (clk200),
        .counter_reset (counter_reset),
        .reg_wr        (reg_wr),
        .reg_addr      (reg_addr),
        .reg_wdata     (reg_wdata),
        .trig_ts       (trig_ts),
        .head_channel  (head_channel),
        .head_ts       (head_ts),
        .empty         (empty),
        .full          (full),
        .count         (buf_count),
        .overrun       (overrun),
        .reg_rdata     (reg_rdata),
        .trigger       (trigger),
        .chan_enable   (chan_enable),
        .pop           (pop),
        .overrun_clear (overrun_clear)
    );

endmodule

/* qpix_daq_checker.sv */
`include "qpix_daq_defines.svh"

module qpix_daq_checker (
    input logic                    clk200,
    input logic                    counter_reset,
    input logic                    trigger,
    input logic                    reg_wr,
    input qpix_daq_pkg::reg_addr_e reg_addr,
    input qpix_daq_pkg::reg_data_t reg_wdata,
    input qpix_daq_pkg::reg_data_t reg_rdata
);

    timeunit 1ns;
    timeprecision 1ps;

    import qpix_daq_pkg::*;

    // raised by any failing assertion, watched from the testbench top
    logic failed = 1'b0;

    //////////////////////////////////////////////////
    // trigger level
    //////////////////////////////////////////////////

    // trigger is low on the cycle after a reset edge
    a_reset_trigger: assert property (@(posedge clk200)
        counter_reset |=> !trigger)
    else
    begin
        $error("[FAIL] %0t: trigger high after reset", $time);
        failed = 1'b1;
    end

    // control bit 0 written high shows up as trigger one cycle later
    a_trigger_rise: assert property (@(posedge clk200) disable iff (counter_reset)
        (reg_wr && reg_addr == reg_control && reg_wdata[0]) |=> trigger)
    else
    begin
        $error("[FAIL] %0t: trigger did not follow control write", $time);
        failed = 1'b1;
    end

    //////////////////////////////////////////////////
    // register reads
    //////////////////////////////////////////////////

    a_id_value: assert property (@(posedge clk200)
        (reg_addr == reg_id) |-> (reg_rdata == `QPIX_ID_VALUE))
    else
    begin
        $error("[FAIL] %0t: id register reads %h", $time, reg_rdata);
        failed = 1'b1;
    end

    // occupancy field never passes the buffer depth
    a_count_bound: assert property (@(posedge clk200) disable iff (counter_reset)
        (reg_addr == reg_event_status) |->
            (reg_rdata[19:16] <= `QPIX_BUF_DEPTH))
    else
    begin
        $error("[FAIL] %0t: event count past depth %h", $time, reg_rdata);
        failed = 1'b1;
    end

endmodule

/* tb_qpix_daq.sv */
`include "qpix_daq_defines.svh"

module tb_qpix_daq;

    timeunit 1ns;
    timeprecision 1ps;

    import qpix_daq_pkg::*;

    // rough length of all sequences in cycles, watchdog allows twice this
    localparam int SEQ_CYCLES = 1500;

    logic                          clk200;
    logic                          counter_reset;
    logic [`QPIX_NUM_CHANNELS-1:0] lvds_hit;
    logic                          reg_wr;
    reg_addr_e                     reg_addr;
    reg_data_t                     reg_wdata;
    reg_data_t                     reg_rdata;
    logic                          trigger;

    // edges since the last reset edge, equals ts(k) after edge k
    longint unsigned ecount;
    int unsigned     last_ch;
    int unsigned     exp_ch [$];
    longint unsigned exp_ts [$];

    qpix_daq_top i_qpix_daq_top (.*);

    bind qpix_daq_top qpix_daq_checker i_checker (.*);

    initial
    begin
        clk200 = 1'b0;
        forever #10 clk200 = ~clk200;
    end

    always @(posedge clk200)
    begin
        if (counter_reset)
            ecount <= 0;
        else
            ecount <= ecount + 1;
    end

    //////////////////////////////////////////////////
    // failure handling
    //////////////////////////////////////////////////

    task automatic stop_failed();
        $display("Simulation failed");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic check(input logic ok, input string msg);
        if (!ok)
        begin
            $error("[FAIL] %0t: %s", $time, msg);
            stop_failed();
        end
    endtask

    // assertion failures in the bound checker end the run here
    initial
    begin
        wait (i_qpix_daq_top.i_checker.failed === 1'b1);
        stop_failed();
    end

    initial
    begin
        #(2 * SEQ_CYCLES * 20);
        $display("timeout: sequences did not finish in time");
        stop_failed();
    end

    //////////////////////////////////////////////////
    // register and hit tasks
    //////////////////////////////////////////////////

    // returns k, the counter value after the write edge
    task automatic write_reg(input reg_addr_e a, input reg_data_t d,
                             output longint unsigned k);
        reg_wr    = 1'b1;
        reg_addr  = a;
        reg_wdata = d;
        @(negedge clk200);
        k      = ecount;
        reg_wr = 1'b0;
    endtask

    task automatic read_reg(input reg_addr_e a, output reg_data_t d);
        reg_addr = a;
        #1;
        d = reg_rdata;
        @(negedge clk200);
    endtask

    // two cycle pulse, stamp is ts(k+1) for first sample edge k
    task automatic hit_pulse(input logic [`QPIX_NUM_CHANNELS-1:0] mask,
                             output longint unsigned ts_exp);
        lvds_hit = lvds_hit | mask;
        @(negedge clk200);
        ts_exp = ecount + 1;
        @(negedge clk200);
        lvds_hit = lvds_hit & ~mask;
    endtask

    task automatic idle(input int n);
        repeat (n) @(negedge clk200);
    endtask

    // poll until the buffer holds n events
    task automatic wait_count(input int n);
        reg_data_t st;
        int        tries;
        tries = 0;
        read_reg(reg_event_status, st);
        while (st[19:16] != n && tries < 100)
        begin
            read_reg(reg_event_status, st);
            tries++;
        end
        check(st[19:16] == n, "event count never reached the expected value");
    endtask

    // head must match the oldest expected event, then it is popped
    task automatic pop_expected();
        reg_data_t       st;
        reg_data_t       lo;
        reg_data_t       hi;
        longint unsigned k;
        int unsigned     ch;
        longint unsigned ts;
        ch = exp_ch.pop_front();
        ts = exp_ts.pop_front();
        wait_count_nonzero(st);
        check(st[3:0] == ch[3:0], "wrong channel at buffer head");
        read_reg(reg_event_lo, lo);
        read_reg(reg_event_hi, hi);
        check({hi, lo} == ts, "wrong timestamp at buffer head");
        write_reg(reg_pop, '0, k);
    endtask

    task automatic wait_count_nonzero(output reg_data_t st);
        int tries;
        tries = 0;
        read_reg(reg_event_status, st);
        while (st[8] && tries < 100)
        begin
            read_reg(reg_event_status, st);
            tries++;
        end
        check(!st[8], "no event arrived at the buffer head");
    endtask

    //////////////////////////////////////////////////
    // sequences
    //////////////////////////////////////////////////

    initial
    begin
        reg_data_t       d;
        longint unsigned k;
        longint unsigned ts;
        int unsigned     ch;
        int unsigned     set [3];
        void'($urandom(32'ha89b));
        counter_reset = 1'b1;
        lvds_hit      = '0;
        reg_wr        = 1'b0;
        reg_addr      = reg_control;
        reg_wdata     = '0;
        repeat (10) @(negedge clk200);
        counter_reset = 1'b0;
        idle(2);

        // after reset
        check(trigger == 1'b0, "trigger high after reset");
        read_reg(reg_event_status, d);
        check(d[8] == 1'b1 && d[19:16] == 0, "buffer not empty after reset");
        read_reg(reg_overrun, d);
        check(d == 0, "overrun bits set after reset");
        read_reg(reg_id, d);
        check(d == `QPIX_ID_VALUE, "wrong id value");

        // trigger capture of ts(k)
        idle(5);
        write_reg(reg_control, 32'h1, k);
        check(trigger == 1'b1, "trigger not raised after control write");
        idle(3);
        read_reg(reg_trig_ts_lo, d);
        check(d == k[31:0], "trigger timestamp low word");
        read_reg(reg_trig_ts_hi, d);
        check(d == k[63:32], "trigger timestamp high word");
        write_reg(reg_control, 32'h0, k);

        // single hits in arrival order
        for (int i = 0; i < 4; i++)
        begin
            ch = $urandom % `QPIX_NUM_CHANNELS;
            hit_pulse(1 << ch, ts);
            exp_ch.push_back(ch);
            exp_ts.push_back(ts);
            last_ch = ch;
            idle(3 + $urandom % 6);
        end
        while (exp_ch.size() > 0)
            pop_expected();

        // disabled channel stays silent
        ch = (last_ch + 1 + $urandom % 15) % `QPIX_NUM_CHANNELS;
        write_reg(reg_chan_enable, ~(32'h1 << ch), k);
        hit_pulse(1 << ch, ts);
        idle(10);
        read_reg(reg_event_status, d);
        check(d[8] == 1'b1, "disabled channel produced an event");
        write_reg(reg_chan_enable, 32'hffff, k);

        // simultaneous hits, round robin after last_ch
        set[0] = $urandom % `QPIX_NUM_CHANNELS;
        set[1] = (set[0] + 1 + $urandom % 7) % `QPIX_NUM_CHANNELS;
        set[2] = (set[1] + 1 + $urandom % 7) % `QPIX_NUM_CHANNELS;
        hit_pulse((1 << set[0]) | (1 << set[1]) | (1 << set[2]), ts);
        for (int j = 1; j <= `QPIX_NUM_CHANNELS; j++)
        begin
            ch = (last_ch + j) % `QPIX_NUM_CHANNELS;
            if (ch == set[0] || ch == set[1] || ch == set[2])
            begin
                exp_ch.push_back(ch);
                exp_ts.push_back(ts);
            end
        end
        while (exp_ch.size() > 0)
            pop_expected();

        // fill the buffer with channels 0 to 7
        for (int i = 0; i < `QPIX_BUF_DEPTH; i++)
        begin
            hit_pulse(1 << i, ts);
            exp_ch.push_back(i);
            exp_ts.push_back(ts);
            idle(3);
        end
        wait_count(`QPIX_BUF_DEPTH);
        read_reg(reg_event_status, d);
        check(d[9] == 1'b1, "full flag not set at depth");

        // channel 9 held pending, second hit overruns it
        hit_pulse(1 << 9, ts);
        exp_ch.push_back(9);
        exp_ts.push_back(ts);
        idle(6);
        read_reg(reg_event_status, d);
        check(d[19:16] == `QPIX_BUF_DEPTH, "count moved past depth");
        hit_pulse(1 << 9, k);
        idle(6);
        read_reg(reg_overrun, d);
        check(d == 32'h200, "overrun bits after second pending hit");
        while (exp_ch.size() > 0)
            pop_expected();
        write_reg(reg_overrun, 32'hffff, k);
        read_reg(reg_overrun, d);
        check(d == 0, "overrun bits not cleared");
        idle(4);

        if (i_qpix_daq_top.i_checker.failed)
            stop_failed();
        else
        begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* all.f */
+incdir+.
qpix_daq_pkg.sv
timestamp_counter.sv
hit_channel.sv
event_arbiter.sv
event_buffer.sv
register_bank.sv
qpix_daq_top.sv
qpix_daq_checker.sv
tb_qpix_daq.sv
